// File: bench/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_ENTRIES  = 64;

    // major opcodes used by the program builder
    localparam int OP_LOAD  = 'h03;
    localparam int OP_IMM   = 'h13;
    localparam int OP_AUIPC = 'h17;
    localparam int OP_LUI   = 'h37;
    localparam int OP_JALR  = 'h67;

    localparam logic [31:0] NOP = 32'h00000013;  // addi x0, x0, 0

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] instr_i;
    logic [31:0] dmem_rdata_i;
    logic [31:0] pc_o;
    logic [31:0] dmem_addr_o;
    logic [31:0] dmem_wdata_o;
    logic        dmem_we_o;
    logic        dmem_re_o;
    logic        rd_we_o;
    logic [4:0]  rd_addr_o;
    logic [31:0] rd_data_o;

    // program table with entry n at instruction address 4 * n
    logic [31:0] instr_tab [MAX_ENTRIES];
    logic        wr_tab    [MAX_ENTRIES];  // register write expected
    logic [4:0]  rd_tab    [MAX_ENTRIES];
    logic [31:0] val_tab   [MAX_ENTRIES];
    logic        st_tab    [MAX_ENTRIES];  // store expected
    logic        ld_tab    [MAX_ENTRIES];  // load expected
    logic [31:0] addr_tab  [MAX_ENTRIES];
    logic [31:0] data_tab  [MAX_ENTRIES];
    logic [31:0] npc_tab   [MAX_ENTRIES];
    int          n_entries   = 0;
    logic        table_ready = 1'b0;

    logic [31:0] dmem [16];

    rv_core #(
        .RESET_PC (32'h0)
    ) rv_core_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .instr_i      (instr_i),
        .dmem_rdata_i (dmem_rdata_i),
        .pc_o         (pc_o),
        .dmem_addr_o  (dmem_addr_o),
        .dmem_wdata_o (dmem_wdata_o),
        .dmem_we_o    (dmem_we_o),
        .dmem_re_o    (dmem_re_o),
        .rd_we_o      (rd_we_o),
        .rd_addr_o    (rd_addr_o),
        .rd_data_o    (rd_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // data memory reads combinationally and writes on the rising edge
    assign dmem_rdata_i = dmem[dmem_addr_o[5:2]];

    always @(posedge clk_i) begin
        if (dmem_we_o) begin
            dmem[dmem_addr_o[5:2]] <= dmem_wdata_o;
        end
    end

    // instruction formats as the ISA lays them out
    function automatic logic [31:0] r_word(input int f7, input int rs2, input int rs1,
                                           input int f3, input int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_word(input int imm, input int rs1, input int f3,
                                           input int rd, input int opc);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_word(input int imm, input int rs2, input int rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_word(input int off, input int rs2, input int rs1,
                                           input int f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    function automatic logic [31:0] u_word(input int imm, input int rd, input int opc);
        return {imm[19:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] j_word(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
    endfunction

    task automatic add_entry(input logic [31:0] instr, input int wr, input int rd,
                             input logic [31:0] val, input int st, input int ld,
                             input logic [31:0] addr, input logic [31:0] data,
                             input int step);
        logic [5:0] slot;
        slot            = n_entries[5:0];
        instr_tab[slot] = instr;
        wr_tab[slot]    = (wr != 0);
        rd_tab[slot]    = rd[4:0];
        val_tab[slot]   = val;
        st_tab[slot]    = (st != 0);
        ld_tab[slot]    = (ld != 0);
        addr_tab[slot]  = addr;
        data_tab[slot]  = data;
        npc_tab[slot]   = 32'(n_entries * 4 + step);  // step is relative to this pc
        n_entries++;
    endtask

    task automatic write_reg(input logic [31:0] instr, input int rd, input logic [31:0] val);
        add_entry(instr, 1, rd, val, 0, 0, 0, 0, 4);
    endtask

    task automatic store_word(input logic [31:0] instr, input logic [31:0] addr,
                              input logic [31:0] data);
        add_entry(instr, 0, 0, 0, 1, 0, addr, data, 4);
    endtask

    task automatic load_word(input logic [31:0] instr, input logic [31:0] addr,
                             input int rd, input logic [31:0] val);
        add_entry(instr, 1, rd, val, 0, 1, addr, 0, 4);
    endtask

    task automatic no_write(input logic [31:0] instr);
        add_entry(instr, 0, 0, 0, 0, 0, 0, 0, 4);
    endtask

    // branches and jumps with rd of zero have no link write
    task automatic control_flow(input logic [31:0] instr, input int rd, input logic [31:0] val,
                                input int step);
        add_entry(instr, int'(rd != 0), rd, val, 0, 0, 0, 0, step);
    endtask

    task automatic build_program();
        write_reg(i_word(5, 0, 0, 1, OP_IMM), 1, 32'd5);                // pc 0
        write_reg(i_word(-3, 0, 0, 2, OP_IMM), 2, 32'hFFFFFFFD);
        write_reg(u_word('h12345, 3, OP_LUI), 3, 32'h12345000);
        write_reg(u_word(1, 4, OP_AUIPC), 4, 32'h0000100C);             // pc 12
        no_write(i_word(7, 0, 0, 0, OP_IMM));                            // x0 stays
        // register-register ops on x1 = 5 and x2 = -3
        write_reg(r_word(0, 2, 1, 0, 5), 5, 32'd2);
        write_reg(r_word('h20, 2, 1, 0, 6), 6, 32'd8);
        write_reg(r_word(0, 1, 2, 2, 7), 7, 32'd1);
        write_reg(r_word(0, 1, 2, 3, 8), 8, 32'd0);
        write_reg(r_word(0, 2, 1, 4, 9), 9, 32'hFFFFFFF8);
        write_reg(r_word(0, 2, 1, 6, 10), 10, 32'hFFFFFFFD);
        write_reg(r_word(0, 2, 1, 7, 11), 11, 32'd5);
        write_reg(r_word(0, 1, 2, 1, 12), 12, 32'hFFFFFFA0);
        write_reg(r_word(0, 1, 2, 5, 13), 13, 32'h07FFFFFF);
        write_reg(r_word('h20, 1, 2, 5, 14), 14, 32'hFFFFFFFF);
        // immediate forms
        write_reg(i_word(-1, 2, 2, 15, OP_IMM), 15, 32'd1);
        write_reg(i_word(-1, 1, 3, 16, OP_IMM), 16, 32'd1);
        write_reg(i_word('h0FF, 1, 4, 17, OP_IMM), 17, 32'h000000FA);
        write_reg(i_word('h0F0, 1, 6, 18, OP_IMM), 18, 32'h000000F5);
        write_reg(i_word('h0F0, 2, 7, 19, OP_IMM), 19, 32'h000000F0);
        write_reg(i_word(4, 1, 1, 20, OP_IMM), 20, 32'h00000050);
        write_reg(i_word(12, 3, 5, 21, OP_IMM), 21, 32'h00012345);
        write_reg(i_word('h401, 2, 5, 22, OP_IMM), 22, 32'hFFFFFFFE);  // srai
        // store then load back the same word
        write_reg(i_word('h20, 0, 0, 23, OP_IMM), 23, 32'h00000020);
        store_word(s_word(4, 3, 23), 32'h00000024, 32'h12345000);
        load_word(i_word(4, 23, 2, 24, OP_LOAD), 32'h00000024, 24, 32'h12345000);
        // each branch first skips one entry and then falls through (pc 104 on)
        control_flow(b_word(8, 1, 1, 0), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 2, 1, 0), 0, 0, 4);
        control_flow(b_word(8, 2, 1, 1), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 1, 1, 1), 0, 0, 4);
        control_flow(b_word(8, 1, 2, 4), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 2, 1, 4), 0, 0, 4);
        control_flow(b_word(8, 2, 1, 5), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 1, 2, 5), 0, 0, 4);
        control_flow(b_word(8, 2, 1, 6), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 1, 2, 6), 0, 0, 4);
        control_flow(b_word(8, 1, 2, 7), 0, 0, 8);
        no_write(NOP);
        control_flow(b_word(8, 2, 1, 7), 0, 0, 4);
        // jal at pc 176 skips two entries and jalr at pc 192 lands on (205 + 4) & ~1
        control_flow(j_word(12, 25), 25, 32'd180, 12);
        no_write(NOP);
        no_write(NOP);
        write_reg(i_word(205, 0, 0, 26, OP_IMM), 26, 32'd205);
        control_flow(i_word(4, 26, 0, 27, OP_JALR), 27, 32'd196, 16);
        no_write(NOP);
        no_write(NOP);
        no_write(NOP);
        no_write(32'h00000073);  // ecall
        no_write(32'h0000000F);  // fence
        no_write(32'h000005FF);  // unknown opcode with rd = x11
        write_reg(r_word(0, 27, 25, 0, 28), 28, 32'd376);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    initial begin
        logic [5:0] idx;
        rst_n_i = 1'b0;
        instr_i = NOP;
        for (int i = 0; i < 16; i++) begin
            dmem[i[3:0]] = 32'hD0D00000 + 32'(i * 4);
        end
        build_program();
        table_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_n_i = 1'b1;
        check_value("pc_o", pc_o, 32'h0);
        while (pc_o < 32'(n_entries * 4)) begin
            idx     = pc_o[7:2];
            instr_i = instr_tab[idx];
            @(negedge clk_i);  // outputs settled mid cycle
            check_value("rd_we_o", {31'b0, rd_we_o}, {31'b0, wr_tab[idx]});
            if (wr_tab[idx]) begin
                check_value("rd_addr_o", {27'b0, rd_addr_o}, {27'b0, rd_tab[idx]});
                check_value("rd_data_o", rd_data_o, val_tab[idx]);
            end
            check_value("dmem_we_o", {31'b0, dmem_we_o}, {31'b0, st_tab[idx]});
            check_value("dmem_re_o", {31'b0, dmem_re_o}, {31'b0, ld_tab[idx]});
            if (st_tab[idx] || ld_tab[idx]) begin
                check_value("dmem_addr_o", dmem_addr_o, addr_tab[idx]);
            end
            if (st_tab[idx]) begin
                check_value("dmem_wdata_o", dmem_wdata_o, data_tab[idx]);
            end
            @(posedge clk_i);
            #1;
            check_value("pc_o", pc_o, npc_tab[idx]);
        end
        $display("Test OK");
        $finish;
    end

    initial begin
        wait (table_ready);
        #((RESET_CYCLES + n_entries + 20) * CLK_PERIOD);
        $display("Timeout: the program did not run to its end in the expected time");
        $display("Test FAILED");
        $fatal(1);
    end

endmodule

// File: common/rv_pkg.sv
package rv_pkg;

    // data path width
    localparam int XLEN = 32;

    // major opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        R       = 7'b0110011,
        I_ALU   = 7'b0010011,
        I_LD    = 7'b0000011,
        S       = 7'b0100011,
        B       = 7'b1100011,
        U_AUIPC = 7'b0010111,
        U_LUI   = 7'b0110111,
        J       = 7'b1101111,
        I_JALR  = 7'b1100111,
        I_ENV   = 7'b1110011,
        FENCE   = 7'b0001111
    } opc_t;

    // alu operation, same codes as funct3 of the op and op-imm groups
    typedef enum logic [2:0] {
        ADD  = 3'b000,  // also SUB with ALT
        SLL  = 3'b001,
        SLT  = 3'b010,
        SLTU = 3'b011,
        XOR  = 3'b100,
        SR   = 3'b101,  // SRL, or SRA with ALT
        OR   = 3'b110,
        AND  = 3'b111
    } alu3_t;

    // funct7 is carried whole so other extensions can reuse it
    typedef logic [6:0] alu7_t;

    localparam alu7_t I_STD = 7'b0000000;
    localparam alu7_t ALT   = 7'b0100000;  // bit 5 picks SUB / SRA

    // branch conditions in funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // first alu operand
    typedef enum logic [1:0] {
        RS1,
        PC,
        ZERO
    } src1_t;

    // second alu operand, also tells the extender which format the immediate has
    typedef enum logic [2:0] {
        RS2,
        IS_IMM12,   // I and S forms share the plain 12 bit extension
        B_IMM12,
        U_IMM,
        J_IMM
    } src2_t;

    // write-back source
    typedef enum logic [1:0] {
        RESULT,
        MEM_DATA,
        NEXT_PC
    } srcr_t;

    // how the pc moves on
    typedef enum logic [1:0] {
        NEXT,
        BRANCH,
        JUMP,
        JUMP_REG
    } next_pc_t;

    // everything the decoder produces apart from register addresses and immediates
    typedef struct packed {
        alu3_t      alu3;
        alu7_t      alu7;
        logic [2:0] funct3;     // raw, the pc unit needs it for branches
        src1_t      src1;
        src2_t      src2;
        srcr_t      srcr;
        logic       reg_write;
        logic       data_read;
        logic       data_write;
        next_pc_t   pc_control;
    } ctrl_t;

endpackage

// File: decoder/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  logic [31:0]   instr_i,

    output rv_pkg::ctrl_t ctrl_o,
    output logic [4:0]    rs1_o,
    output logic [4:0]    rs2_o,
    output logic [4:0]    rd_o,
    output logic [11:0]   imm12_o,  // raw, bits in order but not extended
    output logic [19:0]   imm20_o
);

    rv_pkg::opc_t  opc;
    logic [2:0]    funct3;
    rv_pkg::alu7_t funct7;

    logic [11:0]   i_imm;
    logic [11:0]   s_imm;
    logic [11:0]   b_imm;
    logic [19:0]   u_imm;
    logic [19:0]   j_imm;

    rv_pkg::ctrl_t ctrl;
    logic [11:0]   imm12;

    assign opc    = rv_pkg::opc_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];

    assign rd_o  = instr_i[11:7];
    assign rs1_o = instr_i[19:15];
    assign rs2_o = instr_i[24:20];

    // immediates unscrambled here, the extender does sign and shift
    assign i_imm = instr_i[31:20];
    assign s_imm = {instr_i[31:25], instr_i[11:7]};
    assign b_imm = {instr_i[31], instr_i[7], instr_i[30:25], instr_i[11:8]};
    assign u_imm = instr_i[31:12];
    assign j_imm = {instr_i[31], instr_i[19:12], instr_i[20], instr_i[30:21]};

    always_comb begin
        // defaults describe a no-op that just steps the pc
        ctrl.alu3       = rv_pkg::ADD;
        ctrl.alu7       = rv_pkg::I_STD;
        ctrl.funct3     = funct3;
        ctrl.src1       = rv_pkg::RS1;
        ctrl.src2       = rv_pkg::RS2;
        ctrl.srcr       = rv_pkg::RESULT;
        ctrl.reg_write  = 1'b0;
        ctrl.data_read  = 1'b0;
        ctrl.data_write = 1'b0;
        ctrl.pc_control = rv_pkg::NEXT;
        imm12           = i_imm;

        case (opc)
            rv_pkg::R: begin
                ctrl.alu3      = rv_pkg::alu3_t'(funct3);
                ctrl.alu7      = funct7;
                ctrl.reg_write = 1'b1;
            end

            rv_pkg::I_ALU: begin
                ctrl.alu3      = rv_pkg::alu3_t'(funct3);
                // upper imm bits are funct7 only for right shifts
                ctrl.alu7      = (funct3 == rv_pkg::SR) ? funct7 : rv_pkg::I_STD;
                ctrl.src2      = rv_pkg::IS_IMM12;
                ctrl.reg_write = 1'b1;
            end

            rv_pkg::I_LD: begin  // word load at rs1 + imm
                ctrl.src2      = rv_pkg::IS_IMM12;
                ctrl.srcr      = rv_pkg::MEM_DATA;
                ctrl.reg_write = 1'b1;
                ctrl.data_read = 1'b1;
            end

            rv_pkg::S: begin
                ctrl.src2       = rv_pkg::IS_IMM12;
                ctrl.data_write = 1'b1;
                imm12           = s_imm;
            end

            rv_pkg::B: begin  // alu forms the target, pc unit decides
                ctrl.src1       = rv_pkg::PC;
                ctrl.src2       = rv_pkg::B_IMM12;
                ctrl.pc_control = rv_pkg::BRANCH;
                imm12           = b_imm;
            end

            rv_pkg::U_AUIPC: begin
                ctrl.src1      = rv_pkg::PC;
                ctrl.src2      = rv_pkg::U_IMM;
                ctrl.reg_write = 1'b1;
            end

            rv_pkg::U_LUI: begin
                ctrl.src1      = rv_pkg::ZERO;
                ctrl.src2      = rv_pkg::U_IMM;
                ctrl.reg_write = 1'b1;
            end

            rv_pkg::J: begin
                ctrl.src1       = rv_pkg::PC;
                ctrl.src2       = rv_pkg::J_IMM;
                ctrl.srcr       = rv_pkg::NEXT_PC;  // link
                ctrl.reg_write  = 1'b1;
                ctrl.pc_control = rv_pkg::JUMP;
            end

            rv_pkg::I_JALR: begin  // target is rs1 + imm
                ctrl.src2       = rv_pkg::IS_IMM12;
                ctrl.srcr       = rv_pkg::NEXT_PC;
                ctrl.reg_write  = 1'b1;
                ctrl.pc_control = rv_pkg::JUMP_REG;
            end

            default: begin
                // env calls, fence and unknown opcodes keep the no-op defaults
            end
        endcase
    end

    assign ctrl_o  = ctrl;
    assign imm12_o = imm12;
    assign imm20_o = (ctrl.src2 == rv_pkg::J_IMM) ? j_imm : u_imm;

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
    input  rv_pkg::ctrl_t               ctrl_i,
    input  logic [rv_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]     rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0]     pc_i,
    input  logic [rv_pkg::XLEN-1:0]     imm_i,
    output logic [rv_pkg::XLEN-1:0]     result_o
);

    logic [rv_pkg::XLEN-1:0] op_a;
    logic [rv_pkg::XLEN-1:0] op_b;
    logic [4:0]              shamt;
    logic                    alt;
    logic                    reg_op;

    always_comb begin
        case (ctrl_i.src1)
            rv_pkg::PC:   op_a = pc_i;
            rv_pkg::ZERO: op_a = '0;  // LUI
            default:      op_a = rs1_data_i;
        endcase
    end

    assign reg_op = (ctrl_i.src2 == rv_pkg::RS2);
    assign op_b   = reg_op ? rs2_data_i : imm_i;
    assign shamt  = op_b[4:0];
    assign alt    = |(ctrl_i.alu7 & rv_pkg::ALT);

    always_comb begin
        case (ctrl_i.alu3)
            rv_pkg::ADD: begin
                if (alt && reg_op) begin  // no SUBI in the ISA
                    result_o = op_a - op_b;
                end else begin
                    result_o = op_a + op_b;
                end
            end
            rv_pkg::SLL:  result_o = op_a << shamt;
            rv_pkg::SLT:  result_o = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_pkg::SLTU: result_o = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
            rv_pkg::XOR:  result_o = op_a ^ op_b;
            rv_pkg::SR: begin
                if (alt) begin
                    result_o = $signed(op_a) >>> shamt;  // sign fill
                end else begin
                    result_o = op_a >> shamt;
                end
            end
            rv_pkg::OR:   result_o = op_a | op_b;
            default:      result_o = op_a & op_b;  // AND
        endcase
    end

endmodule

// File: logic/imm_extender.sv
`timescale 1ns/1ps

module imm_extender (
    input  rv_pkg::ctrl_t               ctrl_i,
    input  logic [11:0]                 imm12_i,
    input  logic [19:0]                 imm20_i,
    output logic [rv_pkg::XLEN-1:0]     imm_o
);

    always_comb begin
        case (ctrl_i.src2)
            rv_pkg::IS_IMM12: begin
                imm_o = {{20{imm12_i[11]}}, imm12_i};
            end
            rv_pkg::B_IMM12: begin  // offsets are in half words
                imm_o = {{19{imm12_i[11]}}, imm12_i, 1'b0};
            end
            rv_pkg::J_IMM: begin
                imm_o = {{11{imm20_i[19]}}, imm20_i, 1'b0};
            end
            rv_pkg::U_IMM: begin
                imm_o = {imm20_i, 12'h000};  // upper 20 bits, low part zero
            end
            default: begin
                imm_o = '0;  // register operand, no immediate
            end
        endcase
    end

endmodule

// File: logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  rv_pkg::ctrl_t               ctrl_i,
    input  logic [rv_pkg::XLEN-1:0]     rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0]     rs2_data_i,
    input  logic [rv_pkg::XLEN-1:0]     target_i,  // from the alu
    output logic [rv_pkg::XLEN-1:0]     pc_o,
    output logic [rv_pkg::XLEN-1:0]     pc_plus4_o
);

    logic                    taken;
    logic [rv_pkg::XLEN-1:0] pc_next;

    assign pc_plus4_o = pc_o + 32'd4;

    // branch condition on the two register values
    always_comb begin
        case (ctrl_i.funct3)
            rv_pkg::F3_BEQ:  taken = (rs1_data_i == rs2_data_i);
            rv_pkg::F3_BNE:  taken = (rs1_data_i != rs2_data_i);
            rv_pkg::F3_BLT:  taken = ($signed(rs1_data_i) < $signed(rs2_data_i));
            rv_pkg::F3_BGE:  taken = ($signed(rs1_data_i) >= $signed(rs2_data_i));
            rv_pkg::F3_BLTU: taken = (rs1_data_i < rs2_data_i);
            rv_pkg::F3_BGEU: taken = (rs1_data_i >= rs2_data_i);
            default:         taken = 1'b0;
        endcase
    end

    always_comb begin
        case (ctrl_i.pc_control)
            rv_pkg::BRANCH:   pc_next = taken ? target_i : pc_plus4_o;
            rv_pkg::JUMP:     pc_next = target_i;
            rv_pkg::JUMP_REG: pc_next = {target_i[rv_pkg::XLEN-1:1], 1'b0};
            default:          pc_next = pc_plus4_o;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= RESET_PC;
        end else begin
            pc_o <= pc_next;
        end
    end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  rv_pkg::ctrl_t               ctrl_i,
    input  logic [4:0]                  rs1_i,
    input  logic [4:0]                  rs2_i,
    input  logic [4:0]                  rd_i,
    input  logic [rv_pkg::XLEN-1:0]     alu_result_i,
    input  logic [rv_pkg::XLEN-1:0]     mem_data_i,
    input  logic [rv_pkg::XLEN-1:0]     pc_plus4_i,
    output logic [rv_pkg::XLEN-1:0]     rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]     rs2_data_o,
    output logic [rv_pkg::XLEN-1:0]     wb_data_o
);

    logic [rv_pkg::XLEN-1:0] regs [1:31];  // x0 has no storage

    always_comb begin
        case (ctrl_i.srcr)
            rv_pkg::MEM_DATA: wb_data_o = mem_data_i;
            rv_pkg::NEXT_PC:  wb_data_o = pc_plus4_i;  // link address
            default:          wb_data_o = alu_result_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl_i.reg_write && rd_i != 5'd0) begin
            regs[rd_i] <= wb_data_o;
        end
    end

    assign rs1_data_o = (rs1_i == 5'd0) ? '0 : regs[rs1_i];
    assign rs2_data_o = (rs2_i == 5'd0) ? '0 : regs[rs2_i];

endmodule

// File: logic/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
    parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk_i,
    input  logic                        rst_n_i,
    input  logic [31:0]                 instr_i,
    input  logic [rv_pkg::XLEN-1:0]     dmem_rdata_i,
    output logic [rv_pkg::XLEN-1:0]     pc_o,
    output logic [rv_pkg::XLEN-1:0]     dmem_addr_o,
    output logic [rv_pkg::XLEN-1:0]     dmem_wdata_o,
    output logic                        dmem_we_o,
    output logic                        dmem_re_o,
    output logic                        rd_we_o,
    output logic [4:0]                  rd_addr_o,
    output logic [rv_pkg::XLEN-1:0]     rd_data_o
);

    rv_pkg::ctrl_t           ctrl;
    logic [4:0]              rs1;
    logic [4:0]              rs2;
    logic [4:0]              rd;
    logic [11:0]             imm12;
    logic [19:0]             imm20;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;
    logic [rv_pkg::XLEN-1:0] result;
    logic [rv_pkg::XLEN-1:0] pc_plus4;
    logic [rv_pkg::XLEN-1:0] wb_data;

    decoder decoder_i (
        .instr_i (instr_i),
        .ctrl_o  (ctrl),
        .rs1_o   (rs1),
        .rs2_o   (rs2),
        .rd_o    (rd),
        .imm12_o (imm12),
        .imm20_o (imm20)
    );

    imm_extender imm_extender_i (
        .ctrl_i  (ctrl),
        .imm12_i (imm12),
        .imm20_i (imm20),
        .imm_o   (imm)
    );

    alu alu_i (
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .pc_i       (pc_o),
        .imm_i      (imm),
        .result_o   (result)
    );

    reg_file reg_file_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl),
        .rs1_i        (rs1),
        .rs2_i        (rs2),
        .rd_i         (rd),
        .alu_result_i (result),
        .mem_data_i   (dmem_rdata_i),
        .pc_plus4_i   (pc_plus4),
        .rs1_data_o   (rs1_data),
        .rs2_data_o   (rs2_data),
        .wb_data_o    (wb_data)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .target_i   (result),
        .pc_o       (pc_o),
        .pc_plus4_o (pc_plus4)
    );

    // data memory sees the alu address and the rs2 value
    assign dmem_addr_o  = result;
    assign dmem_wdata_o = rs2_data;
    assign dmem_we_o    = ctrl.data_write;
    assign dmem_re_o    = ctrl.data_read;

    assign rd_we_o   = ctrl.reg_write & (rd != 5'd0);  // x0 writes are dropped
    assign rd_addr_o = rd;
    assign rd_data_o = wb_data;

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module tb_rv_core -o tb_rv_core

out=$(./obj_dir/tb_rv_core 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "Test OK"; then
    exit 0
else
    exit 1
fi

// File: tb.f
common/rv_pkg.sv
decoder/decoder.sv
logic/imm_extender.sv
logic/alu.sv
logic/reg_file.sv
logic/pc_unit.sv
logic/rv_core.sv
bench/tb_rv_core.sv
